/* verilog/AudBusPkg.sv */
// bus encodings and address map of the PCM sound device, referenced by scoped name
package AudBusPkg;

	// bit positions in busOpm
	// load request
	localparam logic [2:0] OpmRead = 3'd3;
	// store request
	localparam logic [2:0] OpmWrite = 3'd4;

	// response codes on busOK
	// nothing pending, or not for us
	localparam logic [1:0] OkReady = 2'd0;
	// access accepted and completed
	localparam logic [1:0] OkOk = 2'd1;
	// not produced here, kept for the bus code space
	localparam logic [1:0] OkHold = 2'd2;
	localparam logic [1:0] OkFault = 2'd3;

	// address bits 27:16 that select this device
	localparam logic [11:0] DevSelect = 12'h009;

	// address bits 15:12, control register page
	localparam logic [3:0] CtrlPage = 4'hF;

	// address bits 15:14, sample memory window
	localparam logic [1:0] SampPage = 2'h0;

	// register word indices from address bits 7:2
	// PCM control
	localparam logic [5:0] RegCtrl0 = 6'd0;
	// beeper divider
	localparam logic [5:0] RegCtrl1 = 6'd1;
	// playback position, read only
	localparam logic [5:0] RegSampPos = 6'd8;

endpackage

/* verilog/AudPcmPkg.sv */
// control register layout, sample rate table and level constants for the PCM datapath
package AudPcmPkg;

	// control register 0 bit positions
	// companded 8-bit samples
	localparam int CtrlCompand = 0;
	// 16-bit samples instead of bytes
	localparam int CtrlUse16b = 1;
	// bit 2 was stereo select, unused in the mono build
	// output enable
	localparam int CtrlEnable = 3;
	// low bit of the 4-bit rate field
	localparam int CtrlRateLsb = 4;

	// divider reload per rate code, in clocks minus one
	// one sample period is reload+1 clocks
	localparam logic [13:0] RateReload [16] = '{
		14'd12500,
		14'd9070,
		14'd6250,
		14'd4535,
		14'd3125,
		14'd2268,
		14'd1562,
		14'd1134,
		14'd781,
		14'd2083,
		14'd781,
		14'd1042,
		14'd781,
		14'd781,
		14'd781,
		14'd781
	};

	// fixed levels that replace the PCM level while the beeper runs
	localparam logic [15:0] BeepHighLevel = 16'h0FFF;
	localparam logic [15:0] BeepLowLevel = 16'hF000;

	// width of every signed PCM level
	localparam int LevelBits = 16;

endpackage

/* verilog/AudBusRegs.sv */
// bus front end: registers host requests, holds both control registers and drives memory writes
`timescale 1ns/1ps

module AudBusRegs #(
	parameter int MemIndexBits = 10
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [31:0]             busAddr,
	input  logic [31:0]             busInData,
	input  logic [4:0]              busOpm,
	input  logic [MemIndexBits+2:0] samplePos,
	output logic [31:0]             busOutData,
	output logic [1:0]              busOK,
	output logic                    memWrite,
	output logic                    memBank,
	output logic [MemIndexBits-1:0] memIndex,
	output logic [31:0]             memData,
	output logic                    useCompand,
	output logic                    use16b,
	output logic                    outEnable,
	output logic [3:0]              rateSelect,
	output logic [15:0]             beepDivide
);

	// request as seen one edge after the host drove it
	logic [31:0] reqAddr;
	logic [31:0] reqData;
	logic [4:0]  reqOpm;

	// decode of the registered request
	logic devSel;
	logic ctrlSel;
	logic sampSel;
	logic isRead;
	logic isWrite;

	// PCM control and beeper divider
	logic [31:0] ctrl0;
	logic [31:0] ctrl1;

	// read mux and registered response
	logic [31:0] readData;
	logic [31:0] respData;
	logic [1:0]  respCode;

	// address and data are payload, only the opcode needs clearing
	always_ff @(posedge clock)
	begin
		reqAddr <= busAddr;
		reqData <= busInData;
		if (reset)
			reqOpm <= '0;
		else
			reqOpm <= busOpm;
	end

	assign devSel = (reqAddr[27:16] == AudBusPkg::DevSelect);
	assign ctrlSel = (reqAddr[15:12] == AudBusPkg::CtrlPage);
	assign sampSel = (reqAddr[15:14] == AudBusPkg::SampPage);
	assign isRead = reqOpm[AudBusPkg::OpmRead];
	assign isWrite = reqOpm[AudBusPkg::OpmWrite];

	// register writes land on the second edge after the request
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ctrl0 <= '0;
			ctrl1 <= '0;
		end
		else if (devSel && isWrite && ctrlSel)
		begin
			case (reqAddr[7:2])
				AudBusPkg::RegCtrl0: ctrl0 <= reqData;
				AudBusPkg::RegCtrl1: ctrl1 <= reqData;
				default:
				begin
				end
			endcase
		end
	end

	// anything unmapped reads as zero
	always_comb
	begin
		readData = '0;
		if (devSel && isRead && ctrlSel)
		begin
			case (reqAddr[7:2])
				AudBusPkg::RegCtrl0: readData = ctrl0;
				AudBusPkg::RegCtrl1: readData = ctrl1;
				AudBusPkg::RegSampPos: readData = 32'(samplePos);
				default: readData = '0;
			endcase
		end
	end

	// response is valid two edges after the request
	always_ff @(posedge clock)
	begin
		respData <= readData;
		if (reset)
			respCode <= AudBusPkg::OkReady;
		else if (devSel && (isRead || isWrite))
			respCode <= AudBusPkg::OkOk;
		else
			respCode <= AudBusPkg::OkReady;
	end

	assign busOutData = respData;
	assign busOK = respCode;

	// sample page store, bit 2 picks the half of a 64-bit block
	assign memWrite = devSel && isWrite && sampSel;
	assign memBank = reqAddr[2];
	assign memIndex = reqAddr[MemIndexBits+2:3];
	assign memData = reqData;

	// control fields fanned out to the blocks
	assign useCompand = ctrl0[AudPcmPkg::CtrlCompand];
	assign use16b = ctrl0[AudPcmPkg::CtrlUse16b];
	assign outEnable = ctrl0[AudPcmPkg::CtrlEnable];
	assign rateSelect = ctrl0[AudPcmPkg::CtrlRateLsb +: 4];
	assign beepDivide = ctrl1[15:0];

endmodule

/* verilog/AudPcmPlayer.sv */
// PCM playback engine: sample memory, rate divider, position counter and four-stage decoder
`timescale 1ns/1ps

module AudPcmPlayer #(
	parameter int MemIndexBits = 10
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             memWrite,
	input  logic                             memBank,
	input  logic [MemIndexBits-1:0]          memIndex,
	input  logic [31:0]                      memData,
	input  logic                             useCompand,
	input  logic                             use16b,
	input  logic [3:0]                       rateSelect,
	output logic [AudPcmPkg::LevelBits-1:0] pcmLevel,
	output logic [MemIndexBits+2:0]          samplePos
);

	// low and high words of each 64-bit block
	logic [31:0] memLow [2**MemIndexBits];
	logic [31:0] memHigh [2**MemIndexBits];

	// rate divider
	logic [13:0] reloadCount;
	logic [13:0] divCount;
	logic [MemIndexBits+2:0] pos;

	// decode pipeline
	logic [MemIndexBits-1:0] readIndex;
	logic [63:0] block;
	logic [2:0]  selPos;
	logic [7:0]  samp8;
	logic [15:0] samp16;
	logic [2:0]  exponent;
	logic [3:0]  mantissa;
	logic [10:0] magnitude;
	logic [11:0] compand12;
	logic [11:0] decoded12;
	logic [11:0] dec12;

	always_ff @(posedge clock)
	begin
		if (memWrite)
		begin
			if (memBank)
				memHigh[memIndex] <= memData;
			else
				memLow[memIndex] <= memData;
		end
	end

	// reload comes from the rate seen one cycle earlier
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reloadCount <= '0;
			divCount <= '0;
			pos <= '0;
		end
		else
		begin
			reloadCount <= AudPcmPkg::RateReload[rateSelect];
			if (divCount == 14'd0)
			begin
				divCount <= reloadCount;
				pos <= pos + 1'b1;
			end
			else
			begin
				divCount <= divCount - 1'b1;
			end
		end
	end

	assign samplePos = pos;

	// eight bytes or four halfwords per block
	assign readIndex = use16b ? pos[MemIndexBits+1:2] : pos[MemIndexBits+2:3];

	// stages 1 and 2, block read then byte or halfword pick
	always_ff @(posedge clock)
	begin
		block <= {memHigh[readIndex], memLow[readIndex]};
		selPos <= pos[2:0];
		samp8 <= block[{selPos, 3'b000} +: 8];
		samp16 <= block[{selPos[1:0], 4'b0000} +: 16];
	end

	// S.E3.M4, exponent zero is denormal
	assign exponent = samp8[6:4];
	assign mantissa = samp8[3:0];

	always_comb
	begin
		if (exponent == 3'd0)
			magnitude = {7'd0, mantissa};
		else
			magnitude = 11'({1'b1, mantissa}) << (exponent - 3'd1);
		// negative samples fold the magnitude below the midpoint
		compand12 = samp8[7] ? {1'b1, ~magnitude} : {1'b0, magnitude};
		if (use16b)
			decoded12 = {samp16[15] ^ ~useCompand, samp16[14:4]};
		else if (useCompand)
			decoded12 = compand12;
		else
			decoded12 = {~samp8[7], samp8[6:0], 4'h0};
	end

	// stages 3 and 4, decode then widen to 16 bits
	always_ff @(posedge clock)
	begin
		dec12 <= decoded12;
		pcmLevel <= {dec12, dec12[11:8]};
	end

endmodule

/* verilog/AudBeeper.sv */
// square-wave beeper clocked by 1 MHz ticks, period set by the beeper divider register
`timescale 1ns/1ps

module AudBeeper (
	input  logic        clock,
	input  logic        reset,
	input  logic        timer1MHz,
	input  logic [15:0] beepDivide,
	output logic        beepActive,
	output logic        beepHigh
);

	// divider value, two stages behind the register
	logic [15:0] divideStage1;
	logic [15:0] divideStage2;
	logic [15:0] divCount;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			divideStage1 <= '0;
			divideStage2 <= '0;
			divCount <= '0;
			beepHigh <= 1'b0;
		end
		else
		begin
			divideStage1 <= beepDivide;
			divideStage2 <= divideStage1;
			// toggle and reload at zero, whether or not a tick is present
			if (divCount == 16'd0)
			begin
				divCount <= divideStage2;
				beepHigh <= ~beepHigh;
			end
			else
			begin
				divCount <= divCount - {15'd0, timer1MHz};
			end
		end
	end

	// a zero divider turns the beeper off
	assign beepActive = (divideStage2 != 16'd0);

endmodule

/* verilog/AudPwmMixer.sv */
// mixes PCM and beep levels into a first-order delta-sigma bit stream with output delay line
`timescale 1ns/1ps

module AudPwmMixer (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [AudPcmPkg::LevelBits-1:0] pcmLevel,
	input  logic                             beepActive,
	input  logic                             beepHigh,
	input  logic                             outEnable,
	output logic [1:0]                       pwmOut,
	output logic                             pwmEna
);

	// registered mix, signed
	logic [15:0] mixLevel;
	// offset binary form fed to the accumulator
	logic [15:0] accIn;
	logic [15:0] acc;
	logic [15:0] accSum;
	logic        carry;
	logic [1:0]  pwmBits;
	// four-stage output delay
	logic [1:0]  outDelay [4];
	logic [3:0]  enaDelay;

	// quarter-scale PCM leaves headroom, beep overrides it
	always_ff @(posedge clock)
	begin
		if (beepActive)
			mixLevel <= beepHigh ? AudPcmPkg::BeepHighLevel : AudPcmPkg::BeepLowLevel;
		else
			mixLevel <= $signed(pcmLevel) >>> 2;
	end

	assign accIn = {~mixLevel[15], mixLevel[14:0]};
	assign {carry, accSum} = {1'b0, acc} + {1'b0, accIn};

	// accumulator parked at zero while output is off
	always_ff @(posedge clock)
	begin
		if (reset || !outEnable)
			acc <= '0;
		else
			acc <= accSum;
	end

	// both bits carry the mono channel, idle level is high
	assign pwmBits = outEnable ? {carry, carry} : 2'b11;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 4; i++)
				outDelay[i] <= 2'b11;
			enaDelay <= '0;
		end
		else
		begin
			outDelay[0] <= pwmBits;
			for (int i = 1; i < 4; i++)
				outDelay[i] <= outDelay[i-1];
			enaDelay <= {enaDelay[2:0], outEnable};
		end
	end

	assign pwmOut = outDelay[3];
	assign pwmEna = enaDelay[3];

endmodule

/* verilog/ModAudPcm.sv */
// top of the bus-mapped mono PCM sound device, wiring bus front end, player, beeper and mixer
`timescale 1ns/1ps

module ModAudPcm #(
	parameter int MemIndexBits = 10
) (
	input  logic        clock,
	input  logic        reset,
	input  logic [31:0] busAddr,
	input  logic [31:0] busInData,
	input  logic [4:0]  busOpm,
	output logic [31:0] busOutData,
	output logic [1:0]  busOK,
	input  logic        timer1MHz,
	output logic [1:0]  pwmOut,
	output logic        pwmEna
);

	// sample memory write port
	logic                    memWrite;
	logic                    memBank;
	logic [MemIndexBits-1:0] memIndex;
	logic [31:0]             memData;

	// control levels
	logic        useCompand;
	logic        use16b;
	logic        outEnable;
	logic [3:0]  rateSelect;
	logic [15:0] beepDivide;

	// block results
	logic [AudPcmPkg::LevelBits-1:0] pcmLevel;
	logic [MemIndexBits+2:0] samplePos;
	logic beepActive;
	logic beepHigh;

	AudBusRegs #(.MemIndexBits(MemIndexBits)) i_AudBusRegs (
		.clock(clock), .reset(reset),
		.busAddr(busAddr), .busInData(busInData), .busOpm(busOpm), .samplePos(samplePos),
		.busOutData(busOutData), .busOK(busOK),
		.memWrite(memWrite), .memBank(memBank), .memIndex(memIndex), .memData(memData),
		.useCompand(useCompand), .use16b(use16b), .outEnable(outEnable),
		.rateSelect(rateSelect), .beepDivide(beepDivide)
	);

	AudPcmPlayer #(.MemIndexBits(MemIndexBits)) i_AudPcmPlayer (
		.clock(clock), .reset(reset),
		.memWrite(memWrite), .memBank(memBank), .memIndex(memIndex), .memData(memData),
		.useCompand(useCompand), .use16b(use16b), .rateSelect(rateSelect),
		.pcmLevel(pcmLevel), .samplePos(samplePos)
	);

	AudBeeper i_AudBeeper (
		.clock(clock), .reset(reset),
		.timer1MHz(timer1MHz), .beepDivide(beepDivide),
		.beepActive(beepActive), .beepHigh(beepHigh)
	);

	AudPwmMixer i_AudPwmMixer (
		.clock(clock), .reset(reset),
		.pcmLevel(pcmLevel), .beepActive(beepActive), .beepHigh(beepHigh),
		.outEnable(outEnable), .pwmOut(pwmOut), .pwmEna(pwmEna)
	);

endmodule

/* tb/ModAudPcm_sva.sv */
// bound checks on bus response codes, PWM idle level and sample position steps of the sound device
`timescale 1ns/1ps

module ModAudPcmSva #(
	parameter int MemIndexBits = 10
) (
	input logic                    clock,
	input logic                    reset,
	input logic [31:0]             busAddr,
	input logic [4:0]              busOpm,
	input logic [1:0]              busOK,
	input logic [1:0]              pwmOut,
	input logic                    pwmEna,
	input logic [MemIndexBits+2:0] samplePos
);

	// failures seen so far, read by the testbench verdict
	int assertFails = 0;

	logic selected;
	logic access;
	logic [MemIndexBits+2:0] prevPos;

	assign selected = (busAddr[27:16] == AudBusPkg::DevSelect);
	assign access = busOpm[AudBusPkg::OpmRead] | busOpm[AudBusPkg::OpmWrite];

	always_ff @(posedge clock)
		prevPos <= samplePos;

	// output held high while disabled
	assert property (@(posedge clock) disable iff (reset) !pwmEna |-> pwmOut == 2'b11)
	else
	begin
		$error("pwmOut not idle high while pwmEna is low");
		assertFails++;
	end

	// not for us or nothing requested
	assert property (@(posedge clock) disable iff (reset)
		(!selected || !access) |-> ##2 busOK == AudBusPkg::OkReady)
	else
	begin
		$error("busOK not ready after idle or unselected request");
		assertFails++;
	end

	assert property (@(posedge clock) disable iff (reset)
		(selected && access) |-> ##2 busOK == AudBusPkg::OkOk)
	else
	begin
		$error("busOK not ok after selected access");
		assertFails++;
	end

	// position holds or steps by one, wrapping at the top
	assert property (@(posedge clock) disable iff (reset)
		samplePos == prevPos || samplePos == prevPos + 1'b1)
	else
	begin
		$error("sample position moved backwards or skipped");
		assertFails++;
	end

endmodule

bind ModAudPcm ModAudPcmSva #(.MemIndexBits(MemIndexBits)) i_ModAudPcmSva (
	.clock(clock), .reset(reset), .busAddr(busAddr), .busOpm(busOpm), .busOK(busOK),
	.pwmOut(pwmOut), .pwmEna(pwmEna), .samplePos(samplePos)
);

/* tb/ModAudPcmTb.sv */
// testbench for the PCM sound device: bus access, playback density and beeper checks, run as top
`timescale 1ns/1ps

module ModAudPcmTb;

	localparam int MemIndexBits = 10;
	// one density window, also one full accumulator cycle
	localparam int Window = 65536;
	localparam int WatchdogCycles = 6 * Window + 20000;
	// rate code 8, reload 781
	localparam int Rate8Period = 782;
	localparam int PosGap = 7820;
	localparam logic [31:0] CtrlBase = 32'h0009_F000;
	localparam logic [31:0] SampBase = 32'h0009_0000;
	localparam logic [31:0] PlayBase = (32'd8 << AudPcmPkg::CtrlRateLsb)
		| (32'd1 << AudPcmPkg::CtrlEnable);

	logic        clock;
	logic        reset;
	logic [31:0] busAddr;
	logic [31:0] busInData;
	logic [4:0]  busOpm;
	logic [31:0] busOutData;
	logic [1:0]  busOK;
	logic        timer1MHz;
	logic [1:0]  pwmOut;
	logic        pwmEna;

	int mismatchCount = 0;
	logic [15:0] lfsrState = 16'd6;

	ModAudPcm #(.MemIndexBits(MemIndexBits)) i_ModAudPcm (
		.clock(clock), .reset(reset), .busAddr(busAddr), .busInData(busInData),
		.busOpm(busOpm), .busOutData(busOutData), .busOK(busOK), .timer1MHz(timer1MHz),
		.pwmOut(pwmOut), .pwmEna(pwmEna)
	);

	always #50 clock = ~clock;

	// galois form, taps 16 14 13 11
	function automatic logic lfsrStep();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 16'hB400;
		return outBit;
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], lfsrStep()};
		return value;
	endfunction

	// 16-bit level of a sample, byte samples in the low 8 bits
	function automatic logic [15:0] decodeLevel(input logic [15:0] samp, input logic compand,
			input logic wide);
		logic [2:0]  expo;
		logic [10:0] mag;
		logic [11:0] v12;
		expo = samp[6:4];
		// exponent zero is denormal, no implied one
		if (expo == 3'd0)
			mag = 11'(samp[3:0]);
		else
			mag = (11'd16 + 11'(samp[3:0])) << (expo - 3'd1);
		if (wide)
			v12 = {samp[15] ^ !compand, samp[14:4]};
		else if (compand)
			v12 = {samp[7], samp[7] ? ~mag : mag};
		else
			v12 = {~samp[7], samp[6:0], 4'h0};
		return {v12, v12[11:8]};
	endfunction

	// quarter scale, then offset binary, is the ones count per window
	function automatic int densityOf(input logic [15:0] level);
		logic [15:0] quarter;
		quarter = $signed(level) >>> 2;
		return int'({~quarter[15], quarter[14:0]});
	endfunction

	// four-state operands so an unknown value never passes as zero
	task automatic checkNear(input string name, input logic signed [63:0] expected,
			input logic signed [63:0] actual, input logic signed [63:0] tolerance);
		logic signed [63:0] diff;
		diff = actual - expected;
		if (diff < 0)
			diff = -diff;
		assert (diff <= tolerance)
		else
		begin
			$display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			mismatchCount++;
		end
	endtask

	task automatic storeWord(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clock);
		busAddr <= addr;
		busInData <= data;
		busOpm <= 5'd1 << AudBusPkg::OpmWrite;
		@(posedge clock);
		busOpm <= '0;
	endtask

	// response registered two edges after the request, sampled mid-cycle
	task automatic loadWord(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clock);
		busAddr <= addr;
		busOpm <= 5'd1 << AudBusPkg::OpmRead;
		@(posedge clock);
		busOpm <= '0;
		@(posedge clock);
		@(negedge clock);
		data = busOutData;
	endtask

	// back to back stores over both banks of every block
	task automatic fillSamples(input logic [31:0] word);
		for (int i = 0; i < 2 ** (MemIndexBits + 1); i++)
		begin
			@(posedge clock);
			busAddr <= SampBase | (32'(i) << 2);
			busInData <= word;
			busOpm <= 5'd1 << AudBusPkg::OpmWrite;
		end
		@(posedge clock);
		busOpm <= '0;
	endtask

	task automatic countOnes(output int ones);
		ones = 0;
		repeat (Window)
		begin
			@(negedge clock);
			if (pwmOut[0] === 1'b1)
				ones++;
		end
	endtask

	initial
	begin
		#(WatchdogCycles * 100);
		$display("timeout: run did not finish within %0d cycles", WatchdogCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		logic [7:0]  sampByte;
		logic [15:0] sampHalf;
		logic [31:0] regVal0;
		logic [31:0] regVal1;
		logic [31:0] readVal;
		logic [31:0] posFirst;
		int ones;
		int expect16;
		int beepMean;
		clock = 1'b0;
		reset = 1'b1;
		busAddr = '0;
		busInData = '0;
		busOpm = '0;
		timer1MHz = 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;

		// idle outputs straight after reset
		@(negedge clock);
		checkNear("pwmEna", 0, pwmEna, 0);
		checkNear("pwmOut", 3, pwmOut, 0);
		checkNear("busOK", AudBusPkg::OkReady, busOK, 0);

		// companded byte playback goes first so memory holds no unknowns
		sampByte = randomBits(8);
		fillSamples({4{sampByte}});

		// control registers keep whatever was written
		regVal0 = randomBits(32);
		regVal1 = randomBits(32);
		storeWord(CtrlBase, regVal0);
		storeWord(CtrlBase + 32'h4, regVal1);
		loadWord(CtrlBase, readVal);
		checkNear("busOutData ctrl0", regVal0, readVal, 0);
		loadWord(CtrlBase + 32'h4, readVal);
		checkNear("busOutData ctrl1", regVal1, readVal, 0);
		// other device and unmapped register
		loadWord(32'h0012_F000, readVal);
		checkNear("busOutData unselected", 0, readVal, 0);
		loadWord(CtrlBase + 32'h10, readVal);
		checkNear("busOutData unmapped", 0, readVal, 0);

		storeWord(CtrlBase + 32'h4, 32'd0);
		storeWord(CtrlBase, PlayBase | (32'd1 << AudPcmPkg::CtrlCompand));
		repeat (300) @(posedge clock);
		countOnes(ones);
		checkNear("pwmOut[0] ones compand", densityOf(decodeLevel({8'h00, sampByte}, 1'b1, 1'b0)),
			ones, 1);

		// rate 8 has been running for a whole window by now
		loadWord(CtrlBase + 32'h20, posFirst);
		repeat (PosGap - 3) @(posedge clock);
		loadWord(CtrlBase + 32'h20, readVal);
		checkNear("samplePos steps", PosGap / Rate8Period,
			(readVal - posFirst) & ((32'd1 << (MemIndexBits + 3)) - 1), 1);

		sampByte = randomBits(8);
		fillSamples({4{sampByte}});
		storeWord(CtrlBase, PlayBase);
		repeat (300) @(posedge clock);
		countOnes(ones);
		checkNear("pwmOut[0] ones linear", densityOf(decodeLevel({8'h00, sampByte}, 1'b0, 1'b0)),
			ones, 1);

		sampHalf = randomBits(16);
		fillSamples({2{sampHalf}});
		storeWord(CtrlBase, PlayBase | (32'd1 << AudPcmPkg::CtrlUse16b));
		repeat (300) @(posedge clock);
		expect16 = densityOf(decodeLevel(sampHalf, 1'b0, 1'b1));
		countOnes(ones);
		checkNear("pwmOut[0] ones 16-bit", expect16, ones, 1);

		// equal high and low halves, 256 cycles each
		beepMean = (int'(AudPcmPkg::BeepHighLevel ^ 16'h8000)
			+ int'(AudPcmPkg::BeepLowLevel ^ 16'h8000)) / 2;
		storeWord(CtrlBase + 32'h4, 32'd255);
		repeat (1000) @(posedge clock);
		countOnes(ones);
		checkNear("pwmOut[0] ones beep", beepMean, ones, 2);

		// beeper off, back to the samples
		storeWord(CtrlBase + 32'h4, 32'd0);
		repeat (300) @(posedge clock);
		countOnes(ones);
		checkNear("pwmOut[0] ones after beep", expect16, ones, 1);

		$display("errors: %0d value mismatches, %0d assertion failures", mismatchCount,
			i_ModAudPcm.i_ModAudPcmSva.assertFails);
		if (mismatchCount == 0 && i_ModAudPcm.i_ModAudPcmSva.assertFails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* ModAudPcm.f */
verilog/AudBusPkg.sv
verilog/AudPcmPkg.sv
verilog/AudBusRegs.sv
verilog/AudPcmPlayer.sv
verilog/AudBeeper.sv
verilog/AudPwmMixer.sv
verilog/ModAudPcm.sv
tb/ModAudPcm_sva.sv
tb/ModAudPcmTb.sv
